//--- build.f
+incdir+source
source/mipsIsaPkg.sv
source/mipsPipePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/memoryStage.sv
source/mipsCore.sv
tb/mipsCore_assert.sv
tb/mipsCoreTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f build.f --top-module mipsCoreTb -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/VmipsCoreTb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

//--- tb/mipsCore_trace.txt
# P <instruction word>, loaded from address 0 up
# S <address> <strobe> <lane-masked data>, E <final loop pc>
# alu chain
P 24010100
P 24021234
P 3C03ABCD
P 00622025
P 00822821
P 00A43023
P 00A43824
P 0082402A
P AC240000
P AC250004
P AC260008
P AC27000C
P AC280010
# loads used at once, partial stores
P 80290003
P AC290014
P 902A0003
P AC2A0018
P 842B0002
P AC2B001C
P 942C0002
P AC2C0020
P 8C2D0004
P A02D0029
P A42D002E
# branches, poison stores behind taken ones
P 11000001
P AC280024
P 15000001
P AC200028
P 8C2E0000
P 11C40001
P AC20002C
P 08000022
P AC200030
P AC200034
# multiply
P 240FFFFD
P 24107000
P 01F00018
P 00008810
P 00009012
P AC310038
P AC32003C
P 1000FFFF
S 00000100 f ABCD1234
S 00000104 f ABCD2468
S 00000108 f 00001234
S 0000010C f ABCD0020
S 00000110 f 00000001
S 00000114 f FFFFFFAB
S 00000118 f 000000AB
S 0000011C f FFFFABCD
S 00000120 f 0000ABCD
S 00000128 2 00006800
S 0000012C c 24680000
S 00000124 f 00000001
S 00000138 f FFFFFFFF
S 0000013C f FFFEB000
E 000000A4

//--- tb/mipsCoreTb.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"
`default_nettype none

module mipsCoreTb;

	logic clk;
	logic reset;
	logic [31:0] pcF, instrF;
	logic memWriteM;
	logic [3:0] byteEnableM;
	logic [31:0] dataAddrM, writeDataM, readDataM;

	// word arrays, 1 KB each
	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];

	// expected stores from the trace
	logic [31:0] expAddr [0:63];
	logic [31:0] expStrobe [0:63];
	logic [31:0] expData [0:63];
	int numStores;
	int storeIdx;
	logic [31:0] endPc;

	mipsCore i_mipsCore (
		.clk(clk),
		.reset(reset),
		.pcF(pcF),
		.instrF(instrF),
		.memWriteM(memWriteM),
		.byteEnableM(byteEnableM),
		.dataAddrM(dataAddrM),
		.writeDataM(writeDataM),
		.readDataM(readDataM)
	);

	// combinational reads on both ports
	assign instrF = imem[pcF[9:2]];
	assign readDataM = dmem[dataAddrM[9:2]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			reportFailure($sformatf("[ERROR] %s: got %h, expected %h",
				name, actual, expected));
		end
	endtask

	// strobe bits to a lane mask
	function automatic logic [31:0] expandStrobes(input logic [3:0] strobes);
		logic [31:0] mask;
		for (int i = 0; i < 4; i++) begin
			mask[8*i +: 8] = {8{strobes[i]}};
		end
		return mask;
	endfunction

	// byte offset of the lowest strobed lane
	function automatic logic [31:0] laneOffset(input logic [3:0] strobes);
		logic [31:0] offset;
		offset = 32'd0;
		for (int i = 3; i >= 0; i--) begin
			if (strobes[i]) offset = i;
		end
		return offset;
	endfunction

	// P word, S addr strobe data, E end pc; # starts a comment line
	task automatic loadTrace();
		int fd;
		logic [7:0] kind;
		int code;
		logic [31:0] loadAddr;
		logic [31:0] a, b, c;
		logic [8*128-1:0] skipped;
		loadAddr = `RESET_PC;
		numStores = 0;
		fd = $fopen("tb/mipsCore_trace.txt", "r");
		if (fd == 0) begin
			reportFailure("could not open the trace file");
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) break;
			if (kind == "#") begin
				code = $fgets(skipped, fd);
			end else if (kind == "P") begin
				code = $fscanf(fd, "%h", a);
				imem[loadAddr[9:2]] = a;
				loadAddr = loadAddr + 32'd4;
			end else if (kind == "S") begin
				code = $fscanf(fd, "%h %h %h", a, b, c);
				expAddr[numStores] = a;
				expStrobe[numStores] = b;
				expData[numStores] = c;
				numStores++;
			end else if (kind == "E") begin
				code = $fscanf(fd, "%h", endPc);
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// data memory writes and store checking
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (!reset && memWriteM) begin
			if (storeIdx >= numStores) begin
				reportFailure($sformatf("unexpected extra store to address %h", dataAddrM));
			end else begin
				// trace holds the word address, the low bits follow the first strobe
				checkValue("dataAddrM", dataAddrM,
					expAddr[storeIdx] | laneOffset(expStrobe[storeIdx][3:0]));
				checkValue("byteEnableM", {28'd0, byteEnableM}, expStrobe[storeIdx]);
				checkValue("writeDataM", writeDataM & expandStrobes(byteEnableM),
					expData[storeIdx]);
				// only the strobed lanes change
				dmem[dataAddrM[9:2]] = (dmem[dataAddrM[9:2]] & ~expandStrobes(byteEnableM))
					| (writeDataM & expandStrobes(byteEnableM));
				storeIdx = storeIdx + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int cycles;
		reset = 1'b1;
		storeIdx = 0;
		endPc = `RESET_PC;
		// unused code words carry an unknown opcode, so a no-op, plus their address
		// data words carry their address
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'hFC00_0000 | i;
			dmem[i] = 32'hA500_0000 | (i << 2);
		end
		loadTrace();

		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			checkValue("pcF", pcF, `RESET_PC);
			checkValue("memWriteM", {31'd0, memWriteM}, 32'd0);
		end
		reset = 1'b0;

		// all stores seen and the final loop reached
		cycles = 0;
		while (!(storeIdx == numStores && pcF == endPc)) begin
			@(negedge clk);
			cycles++;
			if (cycles > 2000) begin
				reportFailure($sformatf("timeout after %0d cycles with %0d of %0d stores",
					cycles, storeIdx, numStores));
			end
		end

		// a few more cycles to catch stray stores
		repeat (20) @(negedge clk);

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/mipsCore_assert.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"
`default_nettype none

module mipsCoreAssert (
	input wire logic        clk,
	input wire logic        reset,
	input wire logic [31:0] pcF,
	input wire logic        memWriteM,
	input wire logic [3:0]  byteEnableM
);

	// one byte, an aligned half or the full word
	legalStrobes: assert property (@(posedge clk) disable iff (reset)
		memWriteM |-> (byteEnableM inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
			4'b0011, 4'b1100, 4'b1111}))
		else $error("illegal byte strobe pattern %b", byteEnableM);

	pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pcF);

	// first cycle out of reset still fetches the reset address
	pcAfterReset: assert property (@(posedge clk) $fell(reset) |-> pcF == `RESET_PC)
		else $error("pc wrong after reset: %h", pcF);

endmodule

bind mipsCore mipsCoreAssert i_mipsCoreAssert (
	.clk(clk),
	.reset(reset),
	.pcF(pcF),
	.memWriteM(memWriteM),
	.byteEnableM(byteEnableM)
);

`default_nettype wire

//--- source/mipsCore.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"
`default_nettype none

module mipsCore import mipsPipePkg::*; (
	input  logic        clk,
	input  logic        reset,
	output logic [31:0] pcF,
	input  logic [31:0] instrF,
	output logic        memWriteM,
	output logic [3:0]  byteEnableM,
	output logic [31:0] dataAddrM,
	output logic [31:0] writeDataM,
	input  logic [31:0] readDataM
);

	fetchDecodeT fdD;
	decodeExecT deE;
	execMemT emM;
	redirectT redirectD;
	wbT wbW;
	fwdSelT fwdAE, fwdBE;
	logic fwdAD, fwdBD, stallF, stallD, flushE, branchD;
	logic [`REG_IDX_W-1:0] rsD, rtD;
	logic [31:0] aluOutM;

	////////////////////////////////////////////////////////////////////////////
	// pipeline stages
	////////////////////////////////////////////////////////////////////////////
	fetchStage i_fetchStage (
		.clk(clk), .reset(reset), .stallF(stallF), .stallD(stallD),
		.redirect(redirectD), .pcF(pcF), .instrF(instrF), .fdOut(fdD)
	);

	decodeStage i_decodeStage (
		.clk(clk), .reset(reset), .stallD(stallD), .flushE(flushE),
		.fdIn(fdD), .wb(wbW), .fwdAD(fwdAD), .fwdBD(fwdBD), .aluOutM(aluOutM),
		.rsD(rsD), .rtD(rtD), .branchD(branchD), .redirect(redirectD), .deOut(deE)
	);

	executeStage i_executeStage (
		.clk(clk), .reset(reset), .deIn(deE), .fwdAE(fwdAE), .fwdBE(fwdBE),
		.wbResult(wbW.result), .emOut(emM), .aluOutM(aluOutM)
	);

	memoryStage i_memoryStage (
		.clk(clk), .reset(reset), .emIn(emM), .memWriteM(memWriteM),
		.byteEnableM(byteEnableM), .dataAddrM(dataAddrM), .writeDataM(writeDataM),
		.readDataM(readDataM), .wb(wbW)
	);

	// forwarding and stalls
	hazardUnit i_hazardUnit (
		.deIn(deE), .emIn(emM), .rsD(rsD), .rtD(rtD), .branchD(branchD), .wb(wbW),
		.fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD),
		.stallF(stallF), .stallD(stallD), .flushE(flushE)
	);

endmodule

`default_nettype wire

//--- source/memoryStage.sv
`timescale 1ns/100ps
`default_nettype none

module memoryStage import mipsIsaPkg::*, mipsPipePkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  execMemT     emIn,
	output logic        memWriteM,
	output logic [3:0]  byteEnableM,
	output logic [31:0] dataAddrM,
	output logic [31:0] writeDataM,
	input  logic [31:0] readDataM,
	output wbT          wb
);

	memWbT mw;
	logic [31:0] readDataW, loadValue;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	assign memWriteM = emIn.memWrite;
	assign dataAddrM = emIn.aluResult;

	// strobes and replicated lanes, little endian
	always_comb begin
		case (emIn.memSize)
			MEM_BYTE: begin
				byteEnableM = 4'b0001 << emIn.aluResult[1:0];
				writeDataM = {4{emIn.storeData[7:0]}};
			end
			MEM_HALF: begin
				byteEnableM = emIn.aluResult[1] ? 4'b1100 : 4'b0011;
				writeDataM = {2{emIn.storeData[15:0]}};
			end
			default: begin
				byteEnableM = 4'b1111;
				writeDataM = emIn.storeData;
			end
		endcase
		// strobes only while storing
		if (!emIn.memWrite) byteEnableM = 4'b0000;
	end

	////////////////////////////////////////////////////////////////////////////
	// memory/writeback register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			mw <= '0;
		end else begin
			mw.aluResult <= emIn.aluResult;
			mw.rd <= emIn.rd;
			mw.regWrite <= emIn.regWrite;
			mw.memRead <= emIn.memRead;
			mw.memSize <= emIn.memSize;
			mw.loadUnsigned <= emIn.loadUnsigned;
		end
	end

	always_ff @(posedge clk) begin
		readDataW <= readDataM;
	end

	// lane pick from the low address bits
	assign loadByte = readDataW[8*mw.aluResult[1:0] +: 8];
	assign loadHalf = mw.aluResult[1] ? readDataW[31:16] : readDataW[15:0];

	always_comb begin
		case (mw.memSize)
			MEM_BYTE: loadValue = mw.loadUnsigned ? {24'd0, loadByte}
				: {{24{loadByte[7]}}, loadByte};
			MEM_HALF: loadValue = mw.loadUnsigned ? {16'd0, loadHalf}
				: {{16{loadHalf[15]}}, loadHalf};
			default:  loadValue = readDataW;
		endcase
	end

	assign wb.regWrite = mw.regWrite;
	assign wb.rd = mw.rd;
	assign wb.result = mw.memRead ? loadValue : mw.aluResult;

endmodule

`default_nettype wire

//--- source/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage import mipsIsaPkg::*, mipsPipePkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  decodeExecT  deIn,
	input  fwdSelT      fwdAE,
	input  fwdSelT      fwdBE,
	input  logic [31:0] wbResult,
	output execMemT     emOut,
	output logic [31:0] aluOutM
);

	logic [31:0] srcA, srcB, opB, aluResult;
	logic [31:0] hi, lo;
	logic [63:0] product;

	assign aluOutM = emOut.aluResult;

	// forwarding muxes
	always_comb begin
		case (fwdAE)
			FWD_MEM: srcA = aluOutM;
			FWD_WB:  srcA = wbResult;
			default: srcA = deIn.srcA;
		endcase
		case (fwdBE)
			FWD_MEM: srcB = aluOutM;
			FWD_WB:  srcB = wbResult;
			default: srcB = deIn.srcB;
		endcase
	end

	assign opB = deIn.aluSrc ? deIn.imm : srcB;

	// low 64 bits of sign-extended operands give the signed product
	assign product = {{32{srcA[31]}}, srcA} * {{32{srcB[31]}}, srcB};

	always_comb begin
		case (deIn.aluOp)
			ALU_ADD:  aluResult = srcA + opB;
			ALU_SUB:  aluResult = srcA - opB;
			ALU_AND:  aluResult = srcA & opB;
			ALU_OR:   aluResult = srcA | opB;
			ALU_SLT:  aluResult = {31'd0, $signed(srcA) < $signed(opB)};
			ALU_LUI:  aluResult = {opB[15:0], 16'd0};
			ALU_MFHI: aluResult = hi;
			ALU_MFLO: aluResult = lo;
			default:  aluResult = product[31:0];
		endcase
	end

	// hi/lo visible to an mfhi right behind the mult
	always_ff @(posedge clk) begin
		if (deIn.hiloWrite) begin
			hi <= product[63:32];
			lo <= product[31:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// execute/memory register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			emOut <= '0;
		end else begin
			emOut.aluResult <= aluResult;
			emOut.storeData <= srcB;
			emOut.rd <= deIn.rd;
			emOut.regWrite <= deIn.regWrite;
			emOut.memRead <= deIn.memRead;
			emOut.memWrite <= deIn.memWrite;
			emOut.memSize <= deIn.memSize;
			emOut.loadUnsigned <= deIn.loadUnsigned;
		end
	end

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"
`default_nettype none

module hazardUnit import mipsPipePkg::*; (
	input  decodeExecT            deIn,
	input  execMemT               emIn,
	input  logic [`REG_IDX_W-1:0] rsD,
	input  logic [`REG_IDX_W-1:0] rtD,
	input  logic                  branchD,
	input  wbT                    wb,
	output fwdSelT                fwdAE,
	output fwdSelT                fwdBE,
	output logic                  fwdAD,
	output logic                  fwdBD,
	output logic                  stallF,
	output logic                  stallD,
	output logic                  flushE
);

	logic loadUse, branchOnExec, branchOnLoad, stall;

	// execute operands, memory wins over writeback
	always_comb begin
		fwdAE = FWD_NONE;
		if (deIn.rs != '0 && emIn.regWrite && emIn.rd == deIn.rs) fwdAE = FWD_MEM;
		else if (deIn.rs != '0 && wb.regWrite && wb.rd == deIn.rs) fwdAE = FWD_WB;
		fwdBE = FWD_NONE;
		if (deIn.rt != '0 && emIn.regWrite && emIn.rd == deIn.rt) fwdBE = FWD_MEM;
		else if (deIn.rt != '0 && wb.regWrite && wb.rd == deIn.rt) fwdBE = FWD_WB;
	end

	// branch operands straight from the memory-stage alu result
	assign fwdAD = rsD != '0 && emIn.regWrite && emIn.rd == rsD;
	assign fwdBD = rtD != '0 && emIn.regWrite && emIn.rd == rtD;

	// load in execute feeding decode
	assign loadUse = deIn.memRead && deIn.rd != '0 && (deIn.rd == rsD || deIn.rd == rtD);

	// branch waits on results not yet available to compare
	assign branchOnExec = branchD && deIn.regWrite && deIn.rd != '0
		&& (deIn.rd == rsD || deIn.rd == rtD);
	assign branchOnLoad = branchD && emIn.memRead && emIn.rd != '0
		&& (emIn.rd == rsD || emIn.rd == rtD);

	assign stall = loadUse | branchOnExec | branchOnLoad;
	assign stallF = stall;
	assign stallD = stall;
	assign flushE = stall;

endmodule

`default_nettype wire

//--- source/decodeStage.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"
`default_nettype none

module decodeStage import mipsIsaPkg::*, mipsPipePkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stallD,
	input  logic                  flushE,
	input  fetchDecodeT           fdIn,
	input  wbT                    wb,
	input  logic                  fwdAD,
	input  logic                  fwdBD,
	input  logic [31:0]           aluOutM,
	output logic [`REG_IDX_W-1:0] rsD,
	output logic [`REG_IDX_W-1:0] rtD,
	output logic                  branchD,
	output redirectT              redirect,
	output decodeExecT            deOut
);

	opcodeT opD;
	functT functD;
	logic [`REG_IDX_W-1:0] rdD, destD;
	logic [31:0] immD, rfA, rfB, cmpA, cmpB;
	logic [31:0] regs [`REG_COUNT];
	logic regWriteD, memReadD, memWriteD, aluSrcD, loadUnsignedD, hiloWriteD;
	logic branchEqD, branchNeD, jumpD, equalD;
	aluOpT aluOpD;
	memSizeT memSizeD;

	// field split
	assign opD = opcodeT'(fdIn.instr[31:26]);
	assign functD = functT'(fdIn.instr[5:0]);
	assign rsD = fdIn.instr[25:21];
	assign rtD = fdIn.instr[20:16];
	assign rdD = fdIn.instr[15:11];
	assign immD = {{16{fdIn.instr[15]}}, fdIn.instr[15:0]};

	////////////////////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		regWriteD = 1'b0;
		memReadD = 1'b0;
		memWriteD = 1'b0;
		aluSrcD = 1'b1;
		loadUnsignedD = 1'b0;
		hiloWriteD = 1'b0;
		branchEqD = 1'b0;
		branchNeD = 1'b0;
		jumpD = 1'b0;
		aluOpD = ALU_ADD;
		memSizeD = MEM_WORD;
		destD = rtD;
		case (opD)
			OP_RTYPE: begin
				aluSrcD = 1'b0;
				destD = rdD;
				case (functD)
					FN_ADDU: begin regWriteD = 1'b1; aluOpD = ALU_ADD; end
					FN_SUBU: begin regWriteD = 1'b1; aluOpD = ALU_SUB; end
					FN_AND:  begin regWriteD = 1'b1; aluOpD = ALU_AND; end
					FN_OR:   begin regWriteD = 1'b1; aluOpD = ALU_OR; end
					FN_SLT:  begin regWriteD = 1'b1; aluOpD = ALU_SLT; end
					FN_MFHI: begin regWriteD = 1'b1; aluOpD = ALU_MFHI; end
					FN_MFLO: begin regWriteD = 1'b1; aluOpD = ALU_MFLO; end
					FN_MULT: begin hiloWriteD = 1'b1; aluOpD = ALU_MULT; end
					// anything else, sll 0 included, is a no-op
					default: ;
				endcase
			end
			OP_ADDIU: regWriteD = 1'b1;
			OP_LUI: begin regWriteD = 1'b1; aluOpD = ALU_LUI; end
			// loads, width and extension from the opcode
			OP_LB:  begin regWriteD = 1'b1; memReadD = 1'b1; memSizeD = MEM_BYTE; end
			OP_LBU: begin
				regWriteD = 1'b1;
				memReadD = 1'b1;
				memSizeD = MEM_BYTE;
				loadUnsignedD = 1'b1;
			end
			OP_LH:  begin regWriteD = 1'b1; memReadD = 1'b1; memSizeD = MEM_HALF; end
			OP_LHU: begin
				regWriteD = 1'b1;
				memReadD = 1'b1;
				memSizeD = MEM_HALF;
				loadUnsignedD = 1'b1;
			end
			OP_LW:  begin regWriteD = 1'b1; memReadD = 1'b1; end
			OP_SB:  begin memWriteD = 1'b1; memSizeD = MEM_BYTE; end
			OP_SH:  begin memWriteD = 1'b1; memSizeD = MEM_HALF; end
			OP_SW:  memWriteD = 1'b1;
			OP_BEQ: branchEqD = 1'b1;
			OP_BNE: branchNeD = 1'b1;
			OP_J:   jumpD = 1'b1;
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////////////////////
	// r0 never written
	always_ff @(posedge clk) begin
		if (wb.regWrite && wb.rd != '0) begin
			regs[wb.rd] <= wb.result;
		end
	end

	// write-through acts as a first-half-cycle write
	always_comb begin
		if (rsD == '0) rfA = '0;
		else if (wb.regWrite && wb.rd == rsD) rfA = wb.result;
		else rfA = regs[rsD];
		if (rtD == '0) rfB = '0;
		else if (wb.regWrite && wb.rd == rtD) rfB = wb.result;
		else rfB = regs[rtD];
	end

	// branch compare with memory-stage forwarding
	assign cmpA = fwdAD ? aluOutM : rfA;
	assign cmpB = fwdBD ? aluOutM : rfB;
	assign equalD = (cmpA == cmpB);
	assign branchD = branchEqD | branchNeD;

	assign redirect.taken = jumpD | (branchEqD & equalD) | (branchNeD & ~equalD);
	assign redirect.target = jumpD ?
		{fdIn.pcPlus4[31:28], fdIn.instr[25:0], 2'b00} :
		fdIn.pcPlus4 + {immD[29:0], 2'b00};

	////////////////////////////////////////////////////////////////////////////
	// decode/execute register
	////////////////////////////////////////////////////////////////////////////
	// a decode stall leaves a bubble behind in execute
	always_ff @(posedge clk) begin
		if (reset || flushE || stallD) begin
			deOut <= '0;
		end else begin
			deOut.srcA <= rfA;
			deOut.srcB <= rfB;
			deOut.imm <= immD;
			deOut.rs <= rsD;
			deOut.rt <= rtD;
			deOut.rd <= destD;
			deOut.aluOp <= aluOpD;
			deOut.aluSrc <= aluSrcD;
			deOut.regWrite <= regWriteD;
			deOut.memRead <= memReadD;
			deOut.memWrite <= memWriteD;
			deOut.loadUnsigned <= loadUnsignedD;
			deOut.hiloWrite <= hiloWriteD;
			deOut.memSize <= memSizeD;
		end
	end

endmodule

`default_nettype wire

//--- source/fetchStage.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"
`default_nettype none

module fetchStage import mipsPipePkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        stallF,
	input  logic        stallD,
	input  redirectT    redirect,
	output logic [31:0] pcF,
	input  logic [31:0] instrF,
	output fetchDecodeT fdOut
);

	logic [31:0] pcPlus4F;
	logic [31:0] pcNext;

	// next pc, sequential or from decode
	assign pcPlus4F = pcF + 32'd4;
	assign pcNext = redirect.taken ? redirect.target : pcPlus4F;

	always_ff @(posedge clk) begin
		if (reset) begin
			pcF <= `RESET_PC;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// fetch/decode register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			fdOut <= '0;
		end else if (!stallD) begin
			// no delay slot, drop the word behind a taken branch
			if (redirect.taken) begin
				fdOut <= '0;
			end else begin
				fdOut.instr <= instrF;
				fdOut.pcPlus4 <= pcPlus4F;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/mipsPipePkg.sv
`include "mipsCore_defines.svh"
`default_nettype none

package mipsPipePkg;
	import mipsIsaPkg::*;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pcPlus4;
	} fetchDecodeT;

	typedef struct packed {
		logic [31:0] srcA;
		logic [31:0] srcB;
		logic [31:0] imm;
		logic [`REG_IDX_W-1:0] rs;
		logic [`REG_IDX_W-1:0] rt;
		logic [`REG_IDX_W-1:0] rd;
		aluOpT aluOp;
		logic aluSrc;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic loadUnsigned;
		logic hiloWrite;
		memSizeT memSize;
	} decodeExecT;

	typedef struct packed {
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [`REG_IDX_W-1:0] rd;
		logic regWrite;
		logic memRead;
		logic memWrite;
		memSizeT memSize;
		logic loadUnsigned;
	} execMemT;

	// load data itself rides in a separate register
	typedef struct packed {
		logic [31:0] aluResult;
		logic [`REG_IDX_W-1:0] rd;
		logic regWrite;
		logic memRead;
		memSizeT memSize;
		logic loadUnsigned;
	} memWbT;

	// decode back to fetch
	typedef struct packed {
		logic taken;
		logic [31:0] target;
	} redirectT;

	// register write port, also the forwarding source
	typedef struct packed {
		logic regWrite;
		logic [`REG_IDX_W-1:0] rd;
		logic [31:0] result;
	} wbT;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_WB   = 2'b01,
		FWD_MEM  = 2'b10
	} fwdSelT;

endpackage

`default_nettype wire

//--- source/mipsIsaPkg.sv
`include "mipsCore_defines.svh"
`default_nettype none

package mipsIsaPkg;

	// primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDIU = 6'b001001,
		OP_LUI   = 6'b001111,
		OP_LB    = 6'b100000,
		OP_LH    = 6'b100001,
		OP_LW    = 6'b100011,
		OP_LBU   = 6'b100100,
		OP_LHU   = 6'b100101,
		OP_SB    = 6'b101000,
		OP_SH    = 6'b101001,
		OP_SW    = 6'b101011
	} opcodeT;

	// r-type function codes, bits 5:0
	typedef enum logic [5:0] {
		FN_MFHI = 6'b010000,
		FN_MFLO = 6'b010010,
		FN_MULT = 6'b011000,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010
	} functT;

	// add is zero so a bubble decodes as a harmless add
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT,
		ALU_LUI, ALU_MULT, ALU_MFHI, ALU_MFLO
	} aluOpT;

	// access width of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} memSizeT;

endpackage

`default_nettype wire

//--- source/mipsCore_defines.svh
`default_nettype none

`ifndef MIPSCORE_DEFINES_SVH
`define MIPSCORE_DEFINES_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000
// general purpose register file
`define REG_COUNT 32
`define REG_IDX_W 5

`endif

`default_nettype wire
